// File: Bender.yml
package:
  name: accExecUnit

sources:
  - include_dirs:
      - include
    files:
      - hdl/isaPkg.sv
      - hdl/execPkg.sv
      - hdl/aluCore.sv
      - hdl/branchUnit.sv
      - hdl/execCommit.sv
      - hdl/apbExecPort.sv
      - hdl/accExecUnit.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/accExecUnit_tb.sv

// File: accExecUnit.f
+incdir+include
hdl/isaPkg.sv
hdl/execPkg.sv
hdl/aluCore.sv
hdl/branchUnit.sv
hdl/execCommit.sv
hdl/apbExecPort.sv
hdl/accExecUnit.sv
tb/accExecUnit_tb.sv

// File: hdl/accExecUnit.sv
`timescale 1ns/1ps
`include "accExec_cfg.svh"

module accExecUnit (
	input logic pclk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_WIDTH-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);

	import isaPkg::*;
	import execPkg::*;

	issueReq issue; // Instruction from the host.
	aluResult result; // Data and flags to commit.
	logic taken; // Branch decision.
	dataWord accA;
	dataWord accB;
	accFlags flags; // Current flag sets.
	pcWord pc;
	logic lastTaken; // Outcome of the last instruction.

	apbExecPort port (
		.pclk(pclk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .issue(issue), .accA(accA), .accB(accB),
		.flags(flags), .pc(pc), .lastTaken(lastTaken)
	);

	aluCore alu (.issue(issue), .accA(accA), .accB(accB), .flags(flags), .result(result));

	branchUnit branch (.op(issue.op), .flags(flags), .taken(taken));

	execCommit commit (
		.pclk(pclk), .rst(rst), .issue(issue), .result(result), .taken(taken),
		.accA(accA), .accB(accB), .flags(flags), .pc(pc), .lastTaken(lastTaken)
	);

endmodule

// File: hdl/aluCore.sv
`timescale 1ns/1ps

module aluCore (
	input execPkg::issueReq issue,
	input isaPkg::dataWord accA,
	input isaPkg::dataWord accB,
	input execPkg::accFlags flags,
	output execPkg::aluResult result
);

	import isaPkg::*;
	import execPkg::*;

	localparam int W = $bits(dataWord); // Data width.

	logic toA; // Result goes to A.
	logic toB; // Result goes to B.
	logic useImm; // Second operand is the immediate.
	dataWord opFirst; // Target accumulator.
	dataWord opSecond; // Other accumulator or immediate.
	logic oldCarry; // Carry of the target, kept by non-arithmetic ops.
	logic [W:0] wide; // Carry bit on top of the result.
	flagSet nf; // Flags of the new result.

	always_comb begin
		toA = 1'b0;
		toB = 1'b0;
		useImm = 1'b0;
		case (issue.op)
			LDA, ADDA, SUBA, ANDA, ORA, ASLA, ASRA: toA = 1'b1;
			ADDCA, SUBCA, ANDCA, ORCA: begin
				toA = 1'b1;
				useImm = 1'b1;
			end
			LDB, ADDB, SUBB, ANDB, ORB: toB = 1'b1;
			ADDCB, SUBCB, ANDCB, ORCB: begin
				toB = 1'b1;
				useImm = 1'b1;
			end
			default: ; // Branches, JMP and NOP write nothing.
		endcase
	end

	assign opFirst = toB ? accB : accA; // SUBB becomes B - A.
	assign opSecond = useImm ? issue.imm : (toB ? accA : accB);
	assign oldCarry = toB ? flags.b.carry : flags.a.carry;

	always_comb begin
		case (issue.op)
			LDA, LDB: wide = {oldCarry, issue.imm};
			ADDA, ADDCA, ADDB, ADDCB: wide = {1'b0, opFirst} + {1'b0, opSecond}; // Ninth bit is carry.
			SUBA, SUBCA, SUBB, SUBCB: wide = {1'b0, opFirst} - {1'b0, opSecond}; // Ninth bit is borrow.
			ANDA, ANDCA, ANDB, ANDCB: wide = {oldCarry, opFirst & opSecond};
			ORA, ORCA, ORB, ORCB: wide = {oldCarry, opFirst | opSecond};
			ASLA: wide = {opFirst, 1'b0}; // MSB falls into carry.
			ASRA: wide = {opFirst[0], opFirst[W-1], opFirst[W-1:1]}; // LSB falls into carry.
			default: wide = {oldCarry, opFirst};
		endcase
	end

	assign nf.carry = wide[W];
	assign nf.zero = ~|wide[W-1:0]; // From the new result.
	assign nf.neg = wide[W-1];

	always_comb begin
		result.wrA = issue.valid & toA;
		result.wrB = issue.valid & toB;
		result.data = wide[W-1:0];
		result.newFlags.a = toA ? nf : flags.a; // Only the target set moves.
		result.newFlags.b = toB ? nf : flags.b;
	end

endmodule

// File: hdl/apbExecPort.sv
`timescale 1ns/1ps
`include "accExec_cfg.svh"

module apbExecPort (
	input logic pclk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [`APB_ADDR_WIDTH-1:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output execPkg::issueReq issue,
	input isaPkg::dataWord accA,
	input isaPkg::dataWord accB,
	input execPkg::accFlags flags,
	input isaPkg::pcWord pc,
	input logic lastTaken
);

	import isaPkg::*;

	logic access; // Second APB phase.
	logic legal; // Offset and direction are mapped.
	logic [31:0] readData; // Selected register.

	assign access = psel & penable;
	assign pready = 1'b1; // No wait states.

	always_comb begin
		legal = 1'b0;
		readData = '0;
		case (paddr)
			`REG_INSTR: legal = 1'b1; // Reads as zero.
			`REG_ACCA: begin
				legal = !pwrite;
				readData = 32'(accA);
			end
			`REG_ACCB: begin
				legal = !pwrite;
				readData = 32'(accB);
			end
			`REG_STATUS: begin
				legal = !pwrite;
				readData = 32'({lastTaken, flags}); // Bit 6 is lastTaken.
			end
			`REG_PC: begin
				legal = !pwrite;
				readData = 32'(pc);
			end
			default: legal = 1'b0;
		endcase
	end

	assign prdata = (access && !pwrite) ? readData : '0;
	assign pslverr = access & ~legal; // Rejected accesses have no effect.

	assign issue.valid = access & pwrite & (paddr == `REG_INSTR);
	assign issue.op = opcode'(pwdata[13:8]); // Unknown codes act as NOP.
	assign issue.imm = pwdata[7:0];

	// Access phase only inside a selected transfer.
	assert property (@(posedge pclk) disable iff (rst) penable |-> psel)
		else $error("penable without psel.");

	// Address and direction hold into the access phase.
	assert property (@(posedge pclk) disable iff (rst)
		psel && !penable |=> $stable(paddr) && $stable(pwrite))
		else $error("APB control changed after setup.");

endmodule

// File: hdl/branchUnit.sv
`timescale 1ns/1ps

module branchUnit (
	input isaPkg::opcode op,
	input execPkg::accFlags flags,
	output logic taken
);

	import isaPkg::*;

	logic condOp; // Opcode changes the flow.
	logic test; // Flag under test.
	logic invert; // Take on flag clear.

	always_comb begin
		condOp = 1'b1;
		test = 1'b0;
		invert = 1'b0;
		case (op)
			JMP: invert = 1'b1; // Inverted zero, always taken.
			BAEQ: test = flags.a.zero;
			BANE: begin
				test = flags.a.zero;
				invert = 1'b1;
			end
			BBEQ: test = flags.b.zero;
			BBNE: begin
				test = flags.b.zero;
				invert = 1'b1;
			end
			BACS: test = flags.a.carry;
			BACC: begin
				test = flags.a.carry;
				invert = 1'b1;
			end
			BBCS: test = flags.b.carry;
			BBCC: begin
				test = flags.b.carry;
				invert = 1'b1;
			end
			BAMI: test = flags.a.neg;
			BAPL: begin
				test = flags.a.neg;
				invert = 1'b1;
			end
			BBMI: test = flags.b.neg;
			BBPL: begin
				test = flags.b.neg;
				invert = 1'b1;
			end
			default: condOp = 1'b0; // ALU ops and NOP fall through.
		endcase
	end

	assign taken = condOp & (test ^ invert);

endmodule

// File: hdl/execCommit.sv
`timescale 1ns/1ps

module execCommit (
	input logic pclk,
	input logic rst,
	input execPkg::issueReq issue,
	input execPkg::aluResult result,
	input logic taken,
	output isaPkg::dataWord accA,
	output isaPkg::dataWord accB,
	output execPkg::accFlags flags,
	output isaPkg::pcWord pc,
	output logic lastTaken
);

	import isaPkg::*;

	pcWord pcNext; // Target or sequential PC.

	assign pcNext = taken ? pcWord'(issue.imm) : pc + 1'b1; // Wraps at 256.

	always_ff @(posedge pclk) begin
		if (rst) begin
			accA <= '0;
			accB <= '0;
			flags <= '0;
			pc <= '0;
			lastTaken <= 1'b0;
		end else if (issue.valid) begin
			if (result.wrA) begin
				accA <= result.data;
			end
			if (result.wrB) begin
				accB <= result.data;
			end
			flags <= result.newFlags; // Unchanged for branches.
			pc <= pcNext;
			lastTaken <= taken; // Zero for non-branch opcodes.
		end
	end

	// Port must stay quiet during reset.
	assert property (@(posedge pclk) rst |-> !issue.valid)
		else $error("Issue during reset.");

	// Decode never targets both accumulators.
	assert property (@(posedge pclk) disable iff (rst) !(result.wrA && result.wrB))
		else $error("Double accumulator write.");

	// A taken branch only moves the PC.
	assert property (@(posedge pclk) disable iff (rst)
		issue.valid && taken |=> $stable(accA) && $stable(accB))
		else $error("Accumulator changed by a branch.");

endmodule

// File: hdl/execPkg.sv
package execPkg;

	// Status bits of one accumulator.
	typedef struct packed {
		logic carry; // Carry out or borrow.
		logic zero; // Result is zero.
		logic neg; // Result bit 7.
	} flagSet;

	// Both flag sets, A in the upper half as in STATUS.
	typedef struct packed {
		flagSet a;
		flagSet b;
	} accFlags;

	// ALU output towards the commit stage.
	typedef struct packed {
		logic wrA; // Write data into A.
		logic wrB; // Write data into B.
		isaPkg::dataWord data; // Result value.
		accFlags newFlags; // Flags after this instruction.
	} aluResult;

	// Instruction handed over by the APB port.
	typedef struct packed {
		logic valid; // High for one access cycle.
		isaPkg::opcode op;
		isaPkg::dataWord imm;
	} issueReq;

endpackage

// File: hdl/isaPkg.sv
`include "accExec_cfg.svh"

package isaPkg;

	typedef logic [`ACC_WIDTH-1:0] dataWord; // Accumulator or immediate.
	typedef logic [`PC_WIDTH-1:0] pcWord; // Program counter value.

	// Instruction opcodes, fixed encodings for the host.
	typedef enum logic [5:0] {
		LDA   = 6'h00, // Load immediate into A.
		LDB   = 6'h01, // Load immediate into B.
		ADDA  = 6'h02, // A + B.
		ADDCA = 6'h03, // A + imm.
		ADDB  = 6'h04, // B + A.
		ADDCB = 6'h05, // B + imm.
		SUBA  = 6'h06, // A - B.
		SUBCA = 6'h07, // A - imm.
		SUBB  = 6'h08, // B - A.
		SUBCB = 6'h09, // B - imm.
		ANDA  = 6'h0A,
		ANDCA = 6'h0B,
		ANDB  = 6'h0C,
		ANDCB = 6'h0D,
		ORA   = 6'h0E,
		ORCA  = 6'h0F,
		ORB   = 6'h10,
		ORCB  = 6'h11,
		ASLA  = 6'h12, // Shift A left.
		ASRA  = 6'h13, // Shift A right, sign kept.
		JMP   = 6'h14, // Unconditional.
		BAEQ  = 6'h15, // Branches on A flags.
		BANE  = 6'h16,
		BBEQ  = 6'h17, // Branches on B flags.
		BBNE  = 6'h18,
		BACS  = 6'h19,
		BACC  = 6'h1A,
		BBCS  = 6'h1B,
		BBCC  = 6'h1C,
		BAMI  = 6'h1D,
		BAPL  = 6'h1E,
		BBMI  = 6'h1F,
		BBPL  = 6'h20,
		NOP   = 6'h3F // Only advances the PC.
	} opcode;

endpackage

// File: include/accExec_cfg.svh
`ifndef ACCEXEC_CFG_SVH
`define ACCEXEC_CFG_SVH

// Datapath widths.
`define ACC_WIDTH 8 // Accumulator width.
`define PC_WIDTH 8 // Program counter width.

// APB side.
`define APB_ADDR_WIDTH 5 // Byte address into the register map.

// Register offsets.
`define REG_INSTR 5'h00 // Opcode in 13:8, immediate in 7:0.
`define REG_ACCA 5'h04 // Accumulator A, read only.
`define REG_ACCB 5'h08 // Accumulator B, read only.
`define REG_STATUS 5'h0C // lastTaken and both flag sets.
`define REG_PC 5'h10 // Program counter.

`endif

// File: tb/accExecUnit_tb.sv
`timescale 1ns/1ps
`include "accExec_cfg.svh"

module accExecUnit_tb;

	import isaPkg::*;

	localparam int RAND_COUNT = 200; // Random ALU instructions.
	localparam int RESET_CYCLES = 8;

	// One table row, expected state after the instruction.
	typedef struct packed {
		opcode op;
		dataWord imm;
		dataWord a;
		dataWord b;
		logic [6:0] status; // lastTaken, then A and B flags.
		pcWord pc;
	} vecEntry;

	logic pclk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`APB_ADDR_WIDTH-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	vecEntry vectors[$]; // Hand-derived test table.
	int cycles; // Clock edges since start.
	int cycleLimit; // Set once the table is known.
	logic [31:0] lcgState;
	dataWord mA; // Model of accumulator A.
	dataWord mB;
	logic [5:0] mFlags; // carryA zeroA negA carryB zeroB negB.
	pcWord mPc;

	accExecUnit DUT (
		.pclk(pclk), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr)
	);

	always #50 pclk = ~pclk; // 100 ns period.

	always @(posedge pclk) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Timeout after %0d cycles, the test did not finish", cycles);
			failRun();
		end
	end

	task automatic failRun();
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got === exp) else begin
			$display("Error %s expected %h got %h", name, exp, got);
			failRun();
		end
	endtask

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Callers start 1 ns after a rising edge and return at the same point.
	task automatic apbWrite(input logic [`APB_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
		output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b1;
		paddr = addr;
		pwdata = data;
		@(posedge pclk);
		#1 penable = 1'b1; // Access phase.
		@(negedge pclk);
		err = pslverr; // Sampled mid-cycle away from the edge.
		checkValue("pready", 32'h1, pready); // No wait states.
		@(posedge pclk);
		#1 psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apbRead(input logic [`APB_ADDR_WIDTH-1:0] addr, output logic [31:0] data,
		output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = addr;
		@(posedge pclk);
		#1 penable = 1'b1;
		@(negedge pclk);
		data = prdata;
		err = pslverr;
		checkValue("pready", 32'h1, pready);
		@(posedge pclk);
		#1 psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic checkReg(input logic [`APB_ADDR_WIDTH-1:0] addr, input string name,
		input logic [31:0] exp);
		logic [31:0] data;
		logic err;
		apbRead(addr, data, err);
		checkValue(name, exp, data);
		checkValue("pslverr", 32'h0, err); // Legal read.
	endtask

	task automatic checkState(input dataWord a, input dataWord b, input logic [6:0] status,
		input pcWord pc);
		checkReg(`REG_ACCA, "accA", a);
		checkReg(`REG_ACCB, "accB", b);
		checkReg(`REG_STATUS, "status", status);
		checkReg(`REG_PC, "pc", pc);
	endtask

	task automatic issueInstr(input opcode op, input dataWord imm);
		logic err;
		apbWrite(`REG_INSTR, {18'h0, op, imm}, err);
		checkValue("pslverr", 32'h0, err);
	endtask

	// Reference model of A, B, flags and PC for ALU opcodes.
	task automatic modelStep(input opcode op, input dataWord imm);
		logic [8:0] t; // Carry or borrow above the result.
		logic toB;
		toB = op inside {LDB, ADDB, ADDCB, SUBB, SUBCB, ANDB, ANDCB, ORB, ORCB};
		case (op)
			LDA: t = {mFlags[5], imm}; // Carry kept.
			LDB: t = {mFlags[2], imm};
			ADDA: t = {1'b0, mA} + mB;
			ADDCA: t = {1'b0, mA} + imm;
			ADDB: t = {1'b0, mB} + mA;
			ADDCB: t = {1'b0, mB} + imm;
			SUBA: t = {1'b0, mA} - mB;
			SUBCA: t = {1'b0, mA} - imm;
			SUBB: t = {1'b0, mB} - mA; // B minus A.
			SUBCB: t = {1'b0, mB} - imm;
			ANDA: t = {mFlags[5], mA & mB};
			ANDCA: t = {mFlags[5], mA & imm};
			ANDB: t = {mFlags[2], mB & mA};
			ANDCB: t = {mFlags[2], mB & imm};
			ORA: t = {mFlags[5], mA | mB};
			ORCA: t = {mFlags[5], mA | imm};
			ORB: t = {mFlags[2], mB | mA};
			ORCB: t = {mFlags[2], mB | imm};
			ASLA: t = {mA, 1'b0}; // Bit 7 out to carry.
			ASRA: t = {mA[0], 8'($signed(mA) >>> 1)};
			default: t = 'x;
		endcase
		if (toB) begin
			mB = t[7:0];
			mFlags[2:0] = {t[8], t[7:0] == 8'h00, t[7]};
		end else begin
			mA = t[7:0];
			mFlags[5:3] = {t[8], t[7:0] == 8'h00, t[7]};
		end
		mPc = mPc + 1'b1;
	endtask

	task automatic addVec(input opcode op, input dataWord imm, input dataWord a, input dataWord b,
		input logic [6:0] status, input pcWord pc);
		vectors.push_back({op, imm, a, b, status, pc});
	endtask

	task automatic loadVectors();
		addVec(LDA, 8'h00, 8'h00, 8'h00, 7'h10, 8'h01); // Zero load.
		addVec(LDB, 8'h80, 8'h00, 8'h80, 7'h11, 8'h02); // Negative load.
		addVec(LDA, 8'hFF, 8'hFF, 8'h80, 7'h09, 8'h03);
		addVec(ADDCA, 8'h01, 8'h00, 8'h80, 7'h31, 8'h04); // FF+01 gives zero and carry.
		addVec(BAEQ, 8'h10, 8'h00, 8'h80, 7'h71, 8'h10);
		addVec(BANE, 8'h20, 8'h00, 8'h80, 7'h31, 8'h11);
		addVec(BBEQ, 8'h20, 8'h00, 8'h80, 7'h31, 8'h12);
		addVec(BBNE, 8'h18, 8'h00, 8'h80, 7'h71, 8'h18);
		addVec(BACS, 8'h20, 8'h00, 8'h80, 7'h71, 8'h20);
		addVec(BACC, 8'h40, 8'h00, 8'h80, 7'h31, 8'h21);
		addVec(BBCS, 8'h40, 8'h00, 8'h80, 7'h31, 8'h22);
		addVec(BBCC, 8'h28, 8'h00, 8'h80, 7'h71, 8'h28);
		addVec(BAMI, 8'h40, 8'h00, 8'h80, 7'h31, 8'h29);
		addVec(BAPL, 8'h30, 8'h00, 8'h80, 7'h71, 8'h30);
		addVec(BBMI, 8'h38, 8'h00, 8'h80, 7'h71, 8'h38);
		addVec(BBPL, 8'h40, 8'h00, 8'h80, 7'h31, 8'h39);
		addVec(LDA, 8'h30, 8'h30, 8'h80, 7'h21, 8'h3A);
		addVec(LDB, 8'h10, 8'h30, 8'h10, 7'h20, 8'h3B);
		addVec(SUBB, 8'h00, 8'h30, 8'hE0, 7'h25, 8'h3C); // A greater than B gives a borrow.
		addVec(ADDA, 8'h00, 8'h10, 8'hE0, 7'h25, 8'h3D);
		addVec(SUBCA, 8'h20, 8'hF0, 8'hE0, 7'h2D, 8'h3E);
		addVec(ADDB, 8'h00, 8'hF0, 8'hD0, 7'h2D, 8'h3F);
		addVec(ANDCA, 8'h0F, 8'h00, 8'hD0, 7'h35, 8'h40); // Old carry kept.
		addVec(ORCB, 8'h0F, 8'h00, 8'hDF, 7'h35, 8'h41);
		addVec(LDA, 8'hC1, 8'hC1, 8'hDF, 7'h2D, 8'h42);
		addVec(ASLA, 8'h00, 8'h82, 8'hDF, 7'h2D, 8'h43);
		addVec(ASRA, 8'h00, 8'hC1, 8'hDF, 7'h0D, 8'h44); // Sign kept and carry cleared.
		addVec(ANDB, 8'h00, 8'hC1, 8'hC1, 7'h0D, 8'h45);
		addVec(ORCA, 8'h3C, 8'hFD, 8'hC1, 7'h0D, 8'h46);
		addVec(LDB, 8'h00, 8'hFD, 8'h00, 7'h0E, 8'h47);
		addVec(BAEQ, 8'h50, 8'hFD, 8'h00, 7'h0E, 8'h48); // Every flag test flipped.
		addVec(BANE, 8'h50, 8'hFD, 8'h00, 7'h4E, 8'h50);
		addVec(BBEQ, 8'h58, 8'hFD, 8'h00, 7'h4E, 8'h58);
		addVec(BBNE, 8'h60, 8'hFD, 8'h00, 7'h0E, 8'h59);
		addVec(BACS, 8'h60, 8'hFD, 8'h00, 7'h0E, 8'h5A);
		addVec(BACC, 8'h60, 8'hFD, 8'h00, 7'h4E, 8'h60);
		addVec(BBCS, 8'h68, 8'hFD, 8'h00, 7'h4E, 8'h68);
		addVec(BBCC, 8'h70, 8'hFD, 8'h00, 7'h0E, 8'h69);
		addVec(BAMI, 8'h70, 8'hFD, 8'h00, 7'h4E, 8'h70);
		addVec(BAPL, 8'h80, 8'hFD, 8'h00, 7'h0E, 8'h71);
		addVec(BBMI, 8'h80, 8'hFD, 8'h00, 7'h0E, 8'h72);
		addVec(BBPL, 8'hFF, 8'hFD, 8'h00, 7'h4E, 8'hFF);
		addVec(SUBA, 8'h00, 8'hFD, 8'h00, 7'h0E, 8'h00); // PC wraps.
		addVec(JMP, 8'hC3, 8'hFD, 8'h00, 7'h4E, 8'hC3);
		addVec(NOP, 8'h00, 8'hFD, 8'h00, 7'h0E, 8'hC4);
	endtask

	initial begin
		logic [31:0] r;
		logic [5:0] sel;
		logic [31:0] rdata;
		logic err;
		vecEntry last;
		pclk = 1'b0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		cycles = 0;
		lcgState = 32'd90; // Seed.
		loadVectors();
		// Five transfers of two cycles per instruction plus reset, doubled.
		cycleLimit = ((vectors.size() + RAND_COUNT) * 5 * 2 + RESET_CYCLES) * 2;
		repeat (RESET_CYCLES) @(posedge pclk);
		#1 rst = 1'b0;
		checkState(8'h00, 8'h00, 7'h00, 8'h00);
		checkReg(`REG_INSTR, "prdata", 32'h0);
		for (int i = 0; i < vectors.size(); i++) begin
			issueInstr(vectors[i].op, vectors[i].imm);
			checkState(vectors[i].a, vectors[i].b, vectors[i].status, vectors[i].pc);
		end
		last = vectors[vectors.size() - 1];
		mA = last.a;
		mB = last.b;
		mFlags = last.status[5:0];
		mPc = last.pc;
		repeat (RAND_COUNT) begin
			r = nextRand();
			sel = 6'(r[31:24] % 8'd20); // LDA through ASRA.
			issueInstr(opcode'(sel), r[23:16]);
			modelStep(opcode'(sel), r[23:16]);
			checkState(mA, mB, {1'b0, mFlags}, mPc);
		end
		apbWrite(`REG_ACCA, 32'h0000_0055, err); // Read-only target.
		checkValue("pslverr", 32'h1, err);
		apbRead(5'h14, rdata, err); // Unmapped offset.
		checkValue("pslverr", 32'h1, err);
		apbWrite(5'h14, {18'h0, LDA, 8'h5A}, err);
		checkValue("pslverr", 32'h1, err);
		checkState(mA, mB, {1'b0, mFlags}, mPc); // Nothing moved.
		$display("Test OK");
		$finish;
	end

endmodule
